/* hdl/regfile_pkg.sv */
// Widths, vector types and the write-port state encoding of the register file.

package regfile_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Six registers leave two address codes unused, so the checker tree
  // always has tied-off leaves.
  localparam int NumRegs   = 6;
  localparam int AddrWidth = 3;
  localparam int DataWidth = 16;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  // Binary register address as sent by the requester.
  typedef logic [AddrWidth-1:0] reg_addr_t;
  // One-hot register select, one bit per register.
  typedef logic [NumRegs-1:0]   reg_sel_t;
  // Register payload.
  typedef logic [DataWidth-1:0] reg_data_t;

  // Write port state. The port only leaves WP_LOCKED through reset.
  typedef enum logic {
    WP_RUN    = 1'b0,
    WP_LOCKED = 1'b1
  } wp_state_e;

endpackage : regfile_pkg

/* hdl/onehot_check.sv */
// Combinational one-hot checker built on explicit binary trees.

`timescale 1ns/1ps

module onehot_check #(
  parameter int unsigned AddrWidth   = 3,
  // May be smaller than 2**AddrWidth. Leaves above it are tied to zero.
  parameter int unsigned OneHotWidth = 2**AddrWidth,
  parameter bit          EnableCheck = 1'b1,
  // Strict mode also flags an enable with an all-zero select.
  parameter bit          StrictCheck = 1'b1,
  parameter bit          AddrCheck   = 1'b1
) (
  input  logic [OneHotWidth-1:0] oh_i,
  input  logic [AddrWidth-1:0]   addr_i,
  input  logic                   en_i,
  output logic                   err_o
);

  //////////////////////////////////////////////////////////////////////
  // Tree storage
  //////////////////////////////////////////////////////////////////////

  // The trees are padded to a full binary tree with AddrWidth levels
  // below the root. Node 0 is the root and the leaves sit at the end.
  localparam int NumNodes = 2**(AddrWidth+1) - 1;

  // OR of all leaves below a node.
  logic [NumNodes-1:0] or_tree;
  // Leaf selected by the address bits below a node.
  logic [NumNodes-1:0] and_tree;
  // Set when two or more leaves below a node are set.
  logic [NumNodes-1:0] err_tree;

  for (genvar lvl = 0; lvl <= AddrWidth; lvl++) begin : gen_level
    // First node index on this level and on the level below it.
    localparam int Base = 2**lvl - 1;
    localparam int BaseChild = 2**(lvl+1) - 1;

    for (genvar idx = 0; idx < 2**lvl; idx++) begin : gen_node
      localparam int Node = Base + idx;

      if (lvl == AddrWidth) begin : gen_leaf
        // Leaf idx stands for address idx.
        if (idx < OneHotWidth) begin : gen_used
          assign or_tree[Node]  = oh_i[idx];
          assign and_tree[Node] = oh_i[idx];
        end else begin : gen_tie_off
          assign or_tree[Node]  = 1'b0;
          assign and_tree[Node] = 1'b0;
        end
        // A single leaf can never hold two set bits.
        assign err_tree[Node] = 1'b0;
      end else begin : gen_inner
        localparam int Left = BaseChild + 2*idx;
        localparam int Right = BaseChild + 2*idx + 1;

        assign or_tree[Node] = or_tree[Left] | or_tree[Right];
        // The address MSB steers the root, lower bits steer deeper levels.
        assign and_tree[Node] = addr_i[AddrWidth-1-lvl] ? and_tree[Right] : and_tree[Left];
        // Both halves active means more than one bit is set.
        assign err_tree[Node] = (or_tree[Left] & or_tree[Right]) |
                                err_tree[Left] | err_tree[Right];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Error combination
  //////////////////////////////////////////////////////////////////////

  logic oh0_err;
  logic enable_err;
  logic addr_err;

  // More than one select bit set anywhere in the vector.
  assign oh0_err = err_tree[0];

  if (EnableCheck && StrictCheck) begin : gen_en_strict
    // Enable and the OR of the select must agree in both directions.
    assign enable_err = en_i ^ or_tree[0];
  end else if (EnableCheck) begin : gen_en_lax
    // Only a select bit without the enable is flagged here.
    assign enable_err = ~en_i & or_tree[0];
  end else begin : gen_en_off
    assign enable_err = 1'b0;
  end

  if (AddrCheck) begin : gen_addr
    // A set bit elsewhere than at addr_i leaves the steered path empty.
    assign addr_err = or_tree[0] ^ and_tree[0];
  end else begin : gen_addr_off
    assign addr_err = 1'b0;
  end

  assign err_o = oh0_err | enable_err | addr_err;

endmodule : onehot_check

/* hdl/write_port_ctrl.sv */
// Write-port controller that checks each request, commits clean writes and locks on error.

`timescale 1ns/1ps

module write_port_ctrl
  import regfile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      wr_valid_i,
  input  reg_addr_t wr_addr_i,
  input  reg_sel_t  wr_sel_i,
  input  reg_data_t wr_data_i,
  output logic      wr_ready_o,
  output logic      alert_o,
  output reg_sel_t  reg_we_o,
  output reg_data_t reg_wdata_o
);

  //////////////////////////////////////////////////////////////////////
  // Request check
  //////////////////////////////////////////////////////////////////////

  logic chk_err;

  // The valid bit acts as the enable, so a select without valid and a
  // valid without select are both errors.
  onehot_check #(
    .AddrWidth   (AddrWidth),
    .OneHotWidth (NumRegs),
    .EnableCheck (1'b1),
    .StrictCheck (1'b1),
    .AddrCheck   (1'b1)
  ) onehot_check_inst (
    .oh_i   (wr_sel_i),
    .addr_i (wr_addr_i),
    .en_i   (wr_valid_i),
    .err_o  (chk_err)
  );

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  wp_state_e state_q;
  wp_state_e state_d;
  logic      ready_q;
  logic      commit;

  // The checker is watched every cycle. Any error ends in WP_LOCKED and
  // only reset brings the port back.
  always_comb begin
    state_d = state_q;
    if (state_q == WP_RUN && chk_err) begin
      state_d = WP_LOCKED;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= WP_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // Ready is its own flop so that it is low during reset and rises
  // in the first cycle after it.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= (state_d == WP_RUN);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Commit and outputs
  //////////////////////////////////////////////////////////////////////

  // A handshake is committed only when the checker is clean.
  assign commit = (state_q == WP_RUN) & wr_valid_i & ready_q & ~chk_err;

  // The storage is enabled straight from the checked one-hot vector.
  assign reg_we_o    = commit ? wr_sel_i : '0;
  assign reg_wdata_o = wr_data_i;

  assign wr_ready_o = ready_q;
  // The alert is sticky because WP_LOCKED is.
  assign alert_o    = (state_q == WP_LOCKED);

endmodule : write_port_ctrl

/* hdl/reg_array.sv */
// Register storage with one-hot write enables and one registered read port.

`timescale 1ns/1ps

module reg_array
  import regfile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  reg_sel_t  reg_we_i,
  input  reg_data_t reg_wdata_i,
  input  reg_addr_t rd_addr_i,
  output reg_data_t rd_data_o
);

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  reg_data_t regs_q [NumRegs];
  reg_data_t rd_data_q;

  // Each register listens to its own enable bit. There is no address
  // decode on the write side, so a corrupted address cannot steer data.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumRegs; i++) begin
        if (reg_we_i[i]) begin
          regs_q[i] <= reg_wdata_i;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Addresses past the last register read as zero.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_data_q <= '0;
    end else if (int'(rd_addr_i) < NumRegs) begin
      rd_data_q <= regs_q[rd_addr_i];
    end else begin
      rd_data_q <= '0;
    end
  end

  assign rd_data_o = rd_data_q;

endmodule : reg_array

/* hdl/regfile_top.sv */
// Top level of the checked register file with its write controller and storage.

`timescale 1ns/1ps

module regfile_top
  import regfile_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  // Write request with valid/ready handshake.
  input  logic      wr_valid_i,
  output logic      wr_ready_o,
  input  reg_addr_t wr_addr_i,
  input  reg_sel_t  wr_sel_i,
  input  reg_data_t wr_data_i,
  // Read port without handshake.
  input  reg_addr_t rd_addr_i,
  output reg_data_t rd_data_o,
  // Sticky error flag.
  output logic      alert_o
);

  // Checked write enables and data between the controller and storage.
  reg_sel_t  reg_we;
  reg_data_t reg_wdata;

  write_port_ctrl write_port_ctrl_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wr_valid_i  (wr_valid_i),
    .wr_addr_i   (wr_addr_i),
    .wr_sel_i    (wr_sel_i),
    .wr_data_i   (wr_data_i),
    .wr_ready_o  (wr_ready_o),
    .alert_o     (alert_o),
    .reg_we_o    (reg_we),
    .reg_wdata_o (reg_wdata)
  );

  reg_array reg_array_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .reg_we_i    (reg_we),
    .reg_wdata_i (reg_wdata),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o)
  );

endmodule : regfile_top

/* tests/regfile_assertions.sv */
// Concurrent assertions on the register file top-level ports, bound to regfile_top.

`timescale 1ns/1ps

module regfile_assertions
  import regfile_pkg::*;
(
  input logic      clk_i,
  input logic      rst_i,
  input logic      wr_valid_i,
  input logic      wr_ready_i,
  input reg_addr_t wr_addr_i,
  input reg_sel_t  wr_sel_i,
  input logic      alert_i
);

  // Count of assertion failures so far.
  int unsigned fail_count = 0;

  logic [2**AddrWidth-1:0] addr_onehot;
  logic [2**AddrWidth-1:0] sel_wide;
  logic                    sel_any;
  logic                    bad_req;

  // Address decoded over all codes, so 6 and 7 can never match a select bit.
  always_comb begin
    addr_onehot = '0;
    addr_onehot[wr_addr_i] = 1'b1;
  end

  assign sel_wide = {{(2**AddrWidth - NumRegs){1'b0}}, wr_sel_i};
  assign sel_any  = |wr_sel_i;
  // Several bits, an enable disagreement, or a bit at the wrong address.
  assign bad_req  = ($countones(wr_sel_i) > 1) | (wr_valid_i != sel_any) |
                    (sel_any & (sel_wide != addr_onehot));

  bad_req_locks: assert property (@(posedge clk_i) disable iff (rst_i) bad_req |=> alert_i)
    else begin
      $error("malformed write request was not followed by alert_o");
      fail_count = fail_count + 1;
    end

  alert_blocks_ready: assert property (@(posedge clk_i) alert_i |-> !wr_ready_i)
    else begin
      $error("wr_ready_o is high while alert_o is set");
      fail_count = fail_count + 1;
    end

  alert_sticky: assert property (@(posedge clk_i) alert_i && !rst_i |=> alert_i)
    else begin
      $error("alert_o dropped without a reset");
      fail_count = fail_count + 1;
    end

  reset_clears: assert property (@(posedge clk_i) rst_i |=> !alert_i && !wr_ready_i)
    else begin
      $error("alert_o or wr_ready_o is high right after a reset cycle");
      fail_count = fail_count + 1;
    end

endmodule : regfile_assertions

bind regfile_top regfile_assertions regfile_assertions_inst (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .wr_valid_i (wr_valid_i),
  .wr_ready_i (wr_ready_o),
  .wr_addr_i  (wr_addr_i),
  .wr_sel_i   (wr_sel_i),
  .alert_i    (alert_o)
);

/* tests/regfile_tb.sv */
// Testbench for the checked register file with clock, reset, stimulus, contents model and reporting.

`timescale 1ns/1ps

module regfile_tb
  import regfile_pkg::*;
();

  // Cycles that any single wait may take before it counts as hung.
  localparam int WaitLimit = 16;

  logic      clk;
  logic      rst;
  logic      wr_valid;
  logic      wr_ready;
  reg_addr_t wr_addr;
  reg_sel_t  wr_sel;
  reg_data_t wr_data;
  reg_addr_t rd_addr;
  reg_data_t rd_data;
  logic      alert;

  // Expected register contents.
  reg_data_t model [NumRegs];

  regfile_top regfile_top_inst (
    .clk_i      (clk),
    .rst_i      (rst),
    .wr_valid_i (wr_valid),
    .wr_ready_o (wr_ready),
    .wr_addr_i  (wr_addr),
    .wr_sel_i   (wr_sel),
    .wr_data_i  (wr_data),
    .rd_addr_i  (rd_addr),
    .rd_data_o  (rd_data),
    .alert_o    (alert)
  );

  // 20 ns clock period.
  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  // A bound assertion that fired is picked up in the low clock phase.
  always @(negedge clk) begin
    if (regfile_top_inst.regfile_assertions_inst.fail_count != 0) begin
      report_failure("a bound assertion on the DUT ports failed");
    end
  end

  // A request is well formed when valid is set and the select holds
  // exactly the bit that the in-range address names.
  function automatic bit is_well_formed(logic valid, reg_addr_t addr, reg_sel_t sel);
    if (!valid || int'(addr) >= NumRegs) begin
      return 1'b0;
    end
    return sel == (reg_sel_t'(1) << addr);
  endfunction

  task automatic idle_write();
    wr_valid = 1'b0;
    wr_sel   = '0;
    wr_addr  = '0;
    wr_data  = '0;
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!wr_ready) begin
      if (cycles == WaitLimit) begin
        report_failure("timeout while waiting for wr_ready_o");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic wait_alert();
    int cycles;
    cycles = 0;
    while (!alert) begin
      if (cycles == WaitLimit) begin
        report_failure("timeout while waiting for alert_o after a bad request");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // Reset for three cycles, then clear the model and wait for the port.
  task automatic apply_reset();
    rst = 1'b1;
    idle_write();
    repeat (3) @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < NumRegs; i++) begin
      model[i] = '0;
    end
    wait_ready();
  endtask

  // Every task starts and ends just after a falling edge.
  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    logic     locked;
    reg_sel_t sel;
    sel      = reg_sel_t'(1) << addr;
    wr_valid = 1'b1;
    wr_addr  = addr;
    wr_sel   = sel;
    wr_data  = data;
    wait_ready();
    // Ready and alert are flop outputs, steady until the next rising edge.
    locked = alert;
    @(posedge clk);
    if (!locked && is_well_formed(1'b1, addr, sel)) begin
      model[addr] = data;
    end
    @(negedge clk);
    idle_write();
  endtask

  task automatic write_random(input int count);
    for (int i = 0; i < count; i++) begin
      write_reg(reg_addr_t'($urandom_range(NumRegs - 1)), reg_data_t'($urandom));
    end
  endtask

  // One cycle of a malformed request, then wait for the lock.
  task automatic send_bad(input logic valid, input reg_addr_t addr, input reg_sel_t sel);
    wr_valid = valid;
    wr_addr  = addr;
    wr_sel   = sel;
    wr_data  = reg_data_t'($urandom);
    @(negedge clk);
    idle_write();
    wait_alert();
  endtask

  // Holds a good request against a locked port, which must not take it.
  task automatic hold_refused(input reg_addr_t addr, input reg_data_t data, input int cycles);
    wr_valid = 1'b1;
    wr_addr  = addr;
    wr_sel   = reg_sel_t'(1) << addr;
    wr_data  = data;
    repeat (cycles) @(negedge clk);
    idle_write();
  endtask

  task automatic read_check(input reg_addr_t addr);
    reg_data_t expected;
    rd_addr = addr;
    @(negedge clk);
    expected = (int'(addr) < NumRegs) ? model[addr] : '0;
    if (rd_data !== expected) begin
      report_failure($sformatf("mismatch at %0t ns: rd_addr %0d read %h, expected %h",
                               $time, addr, rd_data, expected));
    end
  endtask

  // Every address code, the two unused ones included.
  task automatic read_all();
    for (int a = 0; a < 2**AddrWidth; a++) begin
      read_check(reg_addr_t'(a));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(55853));
    clk     = 1'b0;
    rst     = 1'b1;
    rd_addr = '0;
    idle_write();

    // Fill every register, then scatter more writes and read back.
    apply_reset();
    for (int a = 0; a < NumRegs; a++) begin
      write_reg(reg_addr_t'(a), reg_data_t'($urandom));
    end
    write_random(12);
    read_all();

    // Two select bits lock the port. Contents survive until reset.
    send_bad(1'b1, 3'd2, 6'b000101);
    hold_refused(3'd1, 16'hdead, 6);
    read_all();
    apply_reset();
    read_all();
    write_random(8);
    read_all();

    // Select bit disagrees with the address, also for addresses 6 and 7.
    send_bad(1'b1, 3'd3, 6'b000010);
    read_all();
    apply_reset();
    write_reg(3'd0, reg_data_t'($urandom));
    send_bad(1'b1, 3'd6, 6'b000001);
    read_all();
    apply_reset();
    send_bad(1'b1, 3'd7, 6'b100000);
    read_all();
    apply_reset();

    // Enable errors in both directions, each in its own run.
    write_random(4);
    send_bad(1'b1, 3'd4, 6'b000000);
    read_all();
    apply_reset();
    write_random(3);
    send_bad(1'b0, 3'd5, 6'b100000);
    read_all();
    apply_reset();
    write_random(6);
    read_all();

    if (regfile_top_inst.regfile_assertions_inst.fail_count == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      report_failure("a bound assertion on the DUT ports failed");
    end
  end

endmodule : regfile_tb

/* verilog.f */
hdl/regfile_pkg.sv
hdl/onehot_check.sv
hdl/write_port_ctrl.sv
hdl/reg_array.sv
hdl/regfile_top.sv
tests/regfile_assertions.sv
tests/regfile_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := regfile_tb
FILELIST := verilog.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	-./$(BIN) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "\*\*\* TEST FAILED \*\*\*" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
